//--- design/emesh_defines.svh
/* Widths and packet field positions shared by the memory endpoint.
   The memory is 64 bits wide, so the array index is taken from address bits MAW+2..3. */
`ifndef EMESH_DEFINES_SVH
`define EMESH_DEFINES_SVH

// Widths
`define EMESH_AW          32                  // Address and data word
`define EMESH_PW          104                 // Request and response packet
`define EMESH_MAW         10                  // Double-word index bits
`define EMESH_MEM_DEPTH   (1 << `EMESH_MAW)   // 1024 double words

// Packet field positions
`define EMESH_WRITE_BIT   0
`define EMESH_SIZE_LSB    1
`define EMESH_SIZE_MSB    2
`define EMESH_CTRL_LSB    3
`define EMESH_CTRL_MSB    7
`define EMESH_DST_LSB     8
`define EMESH_DST_MSB     39
`define EMESH_DATA_LSB    40
`define EMESH_DATA_MSB    71
`define EMESH_SRC_LSB     72
`define EMESH_SRC_MSB     103

`endif

//--- design/emesh_pkg.sv
/* Types shared by the memory endpoint blocks.
   The size encoding is the 2-bit field carried in the packet. */
package emesh_pkg;

   // Access size, as coded in packet bits 2..1
   typedef enum logic [1:0]
   {
      SIZE_BYTE   = 2'b00,  // 8 bits
      SIZE_HALF   = 2'b01,  // 16 bits
      SIZE_WORD   = 2'b10,  // 32 bits
      SIZE_DOUBLE = 2'b11   // 64 bits, upper word rides in srcaddr
   } size_t;

   // One memory row, eight byte lanes
   typedef logic [63:0] mem_word_t;

   // One bit per byte lane, lane 0 in bit 0
   typedef logic [7:0] byte_en_t;

endpackage

//--- design/emesh_unpack.sv
/* Pure field decode of a request packet, no checks on the contents.
   Positions come from emesh_defines.svh. */
`include "emesh_defines.svh"

module emesh_unpack
   import emesh_pkg::*;
(
   input  logic [`EMESH_PW-1:0] packet_in,
   output logic                 write,     // 1 = write, 0 = read
   output size_t                size,
   output logic [4:0]           ctrl,      // Opaque, echoed in response
   output logic [`EMESH_AW-1:0] dstaddr,   // Memory byte address
   output logic [`EMESH_AW-1:0] data,      // Write data, low word
   output logic [`EMESH_AW-1:0] srcaddr    // Return address or upper data word
);

   // Control fields
   assign write = packet_in[`EMESH_WRITE_BIT];
   assign size  = size_t'(packet_in[`EMESH_SIZE_MSB:`EMESH_SIZE_LSB]);
   assign ctrl  = packet_in[`EMESH_CTRL_MSB:`EMESH_CTRL_LSB];

   // Address and payload fields
   assign dstaddr = packet_in[`EMESH_DST_MSB:`EMESH_DST_LSB];
   assign data    = packet_in[`EMESH_DATA_MSB:`EMESH_DATA_LSB];
   assign srcaddr = packet_in[`EMESH_SRC_MSB:`EMESH_SRC_LSB];

endmodule

//--- design/emesh_pack.sv
/* Builds a packet from its fields, any bit outside a field is zero.
   Same layout as emesh_unpack. */
`include "emesh_defines.svh"

module emesh_pack
   import emesh_pkg::*;
(
   input  logic                 write,
   input  size_t                size,
   input  logic [4:0]           ctrl,
   input  logic [`EMESH_AW-1:0] dstaddr,
   input  logic [`EMESH_AW-1:0] data,
   input  logic [`EMESH_AW-1:0] srcaddr,
   output logic [`EMESH_PW-1:0] packet_out
);

   always_comb
   begin
      packet_out = '0;  // Bits outside the fields stay zero
      packet_out[`EMESH_WRITE_BIT]                 = write;
      packet_out[`EMESH_SIZE_MSB:`EMESH_SIZE_LSB]  = size;
      packet_out[`EMESH_CTRL_MSB:`EMESH_CTRL_LSB]  = ctrl;
      packet_out[`EMESH_DST_MSB:`EMESH_DST_LSB]    = dstaddr;
      packet_out[`EMESH_DATA_MSB:`EMESH_DATA_LSB]  = data;
      packet_out[`EMESH_SRC_MSB:`EMESH_SRC_LSB]    = srcaddr;
   end

endmodule

//--- design/emesh_wralign.sv
/* Write data steering for a 64-bit row. Assumes naturally aligned accesses;
   the low address bits below the access size are ignored. */
`include "emesh_defines.svh"

module emesh_wralign
   import emesh_pkg::*;
(
   input  logic                 write,
   input  size_t                size,
   input  logic [2:0]           addr_lo,   // Byte offset within the row
   input  logic [`EMESH_AW-1:0] data,
   input  logic [`EMESH_AW-1:0] srcaddr,   // Upper word of a double
   output mem_word_t            wdata,
   output byte_en_t             byte_en
);

   // ####################################################################
   // Data replication
   // ####################################################################

   // Every lane gets a copy and the mask picks the one that lands
   always_comb
   begin
      case (size)
         SIZE_BYTE:   wdata = {8{data[7:0]}};
         SIZE_HALF:   wdata = {4{data[15:0]}};
         SIZE_WORD:   wdata = {2{data}};
         default:     wdata = {srcaddr, data};   // Double
      endcase
   end

   // ####################################################################
   // Byte enables
   // ####################################################################

   always_comb
   begin
      if (!write)
      begin
         byte_en = '0;   // Reads touch no lane
      end
      else
      begin
         case (size)
            SIZE_BYTE:   byte_en = byte_en_t'(8'b0000_0001 << addr_lo);
            SIZE_HALF:   byte_en = byte_en_t'(8'b0000_0011 << {addr_lo[2:1], 1'b0});
            SIZE_WORD:   byte_en = byte_en_t'(8'b0000_1111 << {addr_lo[2], 2'b00});
            default:     byte_en = 8'b1111_1111;
         endcase
      end
   end

endmodule

//--- design/sram_sp.sv
/* Single-port RAM, one cycle read latency. Contents are undefined after
   power-up; rdata changes only on an enabled cycle. */
`include "emesh_defines.svh"

module sram_sp
   import emesh_pkg::*;
(
   input  logic                  clk,
   input  logic                  en,        // Access this cycle
   input  logic                  we,        // Write, qualified by byte_en
   input  byte_en_t              byte_en,
   input  logic [`EMESH_MAW-1:0] addr,      // Row index
   input  mem_word_t             wdata,
   output mem_word_t             rdata      // Old contents on a write
);

   mem_word_t mem [`EMESH_MEM_DEPTH];

   // Array write, per byte lane
   always_ff @(posedge clk)
   begin
      if (en && we)
      begin
         for (int i = 0; i < 8; i++)
         begin
            if (byte_en[i])
               mem[addr][8*i +: 8] <= wdata[8*i +: 8];
         end
      end
   end

   // Output register, holds while idle
   always_ff @(posedge clk)
   begin
      if (en)
         rdata <= mem[addr];   // Read-during-write returns the old row
   end

endmodule

//--- design/emesh_rdalign.sv
/* Read data alignment; lanes follow the same natural alignment as the write side.
   A double returns only its low word here, the top level forwards the upper one. */
`include "emesh_defines.svh"

module emesh_rdalign
   import emesh_pkg::*;
(
   input  size_t                size,
   input  logic [2:0]           addr_lo,
   input  mem_word_t            rdata,
   output logic [`EMESH_AW-1:0] data_out
);

   mem_word_t shifted;   // Addressed lane moved down to bit 0

   always_comb
   begin
      // Offset rounded down to the access size
      case (size)
         SIZE_BYTE:   shifted = rdata >> {addr_lo, 3'b000};
         SIZE_HALF:   shifted = rdata >> {addr_lo[2:1], 4'b0000};
         SIZE_WORD:   shifted = rdata >> {addr_lo[2], 5'b00000};
         default:     shifted = rdata;
      endcase

      // Zero-extend the lane
      case (size)
         SIZE_BYTE:   data_out = {24'b0, shifted[7:0]};
         SIZE_HALF:   data_out = {16'b0, shifted[15:0]};
         default:     data_out = shifted[31:0];   // Word or low half of double
      endcase
   end

endmodule

//--- design/emesh_wait_ctrl.sv
/* Pseudo-random hold-off for incoming requests. Disabled after reset;
   a wider mask gives longer and more frequent stalls, mask 0 never stalls. */
module emesh_wait_ctrl
(
   input  logic       clk,
   input  logic       nreset,
   input  logic       cfg_write,
   input  logic [8:0] cfg_wdata,   // [8] enable, [7:0] mask
   output logic       permit       // High when a request may be accepted
);

   localparam logic [15:0] LFSR_SEED = 16'hACE1;
   localparam logic [15:0] LFSR_TAPS = 16'hB400;   // x^16+x^14+x^13+x^11+1

   logic        wait_en;
   logic [7:0]  wait_mask;
   logic [15:0] lfsr;

   // Configuration registers
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         wait_en   <= 1'b0;
         wait_mask <= '0;
      end
      else if (cfg_write)
      begin
         wait_en   <= cfg_wdata[8];
         wait_mask <= cfg_wdata[7:0];
      end
   end

   // Galois LFSR, free running, shifts right
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         lfsr <= LFSR_SEED;
      else
         lfsr <= {1'b0, lfsr[15:1]} ^ (lfsr[0] ? LFSR_TAPS : 16'h0000);
   end

   // Permit level
   assign permit = !wait_en || ((lfsr[7:0] & wait_mask) == 8'h00);

endmodule

//--- design/emesh_memory.sv
/* Memory endpoint, one read in flight. Writes get no response;
   a pending read response blocks new requests until ready_in takes it. */
`include "emesh_defines.svh"

module emesh_memory
   import emesh_pkg::*;
(
   input  logic                 clk,
   input  logic                 nreset,
   // Requests from the mesh
   input  logic                 valid_in,
   input  logic [`EMESH_PW-1:0] packet_in,
   output logic                 ready_out,
   // Read responses back to the mesh
   output logic                 valid_out,
   output logic [`EMESH_PW-1:0] packet_out,
   input  logic                 ready_in,
   // Wait pattern setup
   input  logic                 cfg_write,
   input  logic [8:0]           cfg_wdata
);

   // Decoded request
   logic                 req_write;
   size_t                req_size;
   logic [4:0]           req_ctrl;
   logic [`EMESH_AW-1:0] req_dstaddr;
   logic [`EMESH_AW-1:0] req_data;
   logic [`EMESH_AW-1:0] req_srcaddr;

   logic                 permit;
   logic                 accept;
   mem_word_t            mem_wdata;
   byte_en_t             mem_byte_en;
   mem_word_t            mem_rdata;

   // Response register payload
   size_t                resp_size;
   logic [4:0]           resp_ctrl;
   logic [2:0]           resp_addr_lo;
   logic [`EMESH_AW-1:0] resp_dstaddr;
   logic [`EMESH_AW-1:0] resp_data;
   logic [`EMESH_AW-1:0] resp_srcaddr;

   // ####################################################################
   // Request side
   // ####################################################################

   emesh_unpack unpack_i (.packet_in(packet_in), .write(req_write), .size(req_size),
                          .ctrl(req_ctrl), .dstaddr(req_dstaddr), .data(req_data),
                          .srcaddr(req_srcaddr));

   emesh_wait_ctrl wait_i (.clk(clk), .nreset(nreset), .cfg_write(cfg_write),
                           .cfg_wdata(cfg_wdata), .permit(permit));

   // Free slot, or the pending response leaves this edge
   assign ready_out = permit && (!valid_out || ready_in);
   assign accept    = valid_in && ready_out;

   emesh_wralign wralign_i (.write(req_write), .size(req_size), .addr_lo(req_dstaddr[2:0]),
                            .data(req_data), .srcaddr(req_srcaddr),
                            .wdata(mem_wdata), .byte_en(mem_byte_en));

   // Row index drops the byte offset
   sram_sp sram_i (.clk(clk), .en(accept), .we(req_write), .byte_en(mem_byte_en),
                   .addr(req_dstaddr[`EMESH_MAW+2:3]), .wdata(mem_wdata),
                   .rdata(mem_rdata));

   // ####################################################################
   // Response side
   // ####################################################################

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         valid_out <= 1'b0;
      else if (accept && !req_write)
         valid_out <= 1'b1;          // Read accepted this edge
      else if (ready_in)
         valid_out <= 1'b0;          // Drained and nothing new
   end

   // Fields follow the read that owns the SRAM output
   always_ff @(posedge clk)
   begin
      if (accept && !req_write)
      begin
         resp_size    <= req_size;
         resp_ctrl    <= req_ctrl;
         resp_addr_lo <= req_dstaddr[2:0];
         resp_dstaddr <= req_srcaddr;   // Return to sender
      end
   end

   emesh_rdalign rdalign_i (.size(resp_size), .addr_lo(resp_addr_lo), .rdata(mem_rdata),
                            .data_out(resp_data));

   assign resp_srcaddr = (resp_size == SIZE_DOUBLE) ? mem_rdata[63:32] : '0;

   emesh_pack pack_i (.write(1'b1), .size(resp_size), .ctrl(resp_ctrl),
                      .dstaddr(resp_dstaddr), .data(resp_data), .srcaddr(resp_srcaddr),
                      .packet_out(packet_out));

endmodule

//--- sim/tb_clkgen.sv
/* Free-running 8 ns clock, nreset low for the first 3 rising edges */
module tb_clkgen
(
   output logic clk,
   output logic nreset
);
   timeunit 1ns;
   timeprecision 100ps;

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;   // 8 ns period
   end

   initial
   begin
      nreset = 1'b0;
      repeat (3) @(posedge clk);
      #1 nreset = 1'b1;        // Release just after the third edge
   end

endmodule

//--- sim/emesh_memory_tb.sv
/* Directed tests on rows 0..31 only; test 2 fills them before any other read.
   Inputs change 1 ns after a rising edge, outputs are sampled on the falling edge. */
`include "emesh_defines.svh"

module emesh_memory_tb
   import emesh_pkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int PW      = `EMESH_PW;
   localparam int TIMEOUT = 20000;   // Cycles per wait, long enough for mask FF stalls
   localparam int ROWS    = 32;

   logic          clk;
   logic          nreset;
   logic          valid_in;
   logic [PW-1:0] packet_in;
   logic          ready_out;
   logic          valid_out;
   logic [PW-1:0] packet_out;
   logic          ready_in;
   logic          cfg_write;
   logic [8:0]    cfg_wdata;

   logic [15:0]   rng_state = 16'd60;   // Stimulus LFSR
   logic [7:0]    ref_mem [ROWS*8];      // Reference model with one entry per byte
   int            stall_cycles = 0;      // Request cycles held off by ready_out

   tb_clkgen clkgen_i (.clk(clk), .nreset(nreset));

   emesh_memory dut_i (.clk(clk), .nreset(nreset), .valid_in(valid_in),
                       .packet_in(packet_in), .ready_out(ready_out),
                       .valid_out(valid_out), .packet_out(packet_out),
                       .ready_in(ready_in), .cfg_write(cfg_write), .cfg_wdata(cfg_wdata));

   // ####################################################################
   // Helpers
   // ####################################################################

   // Galois LFSR x^16+x^15+x^13+x^4+1 stepped once per bit
   function automatic logic next_bit();
      logic out;
      out       = rng_state[0];
      rng_state = {1'b0, rng_state[15:1]} ^ (out ? 16'hD008 : 16'h0000);
      return out;
   endfunction

   function automatic logic [31:0] random_bits(int n);
      logic [31:0] value;
      value = '0;
      for (int i = 0; i < n; i++)
         value = {value[30:0], next_bit()};
      return value;
   endfunction

   // Fields from MSB down are src, data, dst, ctrl, size, write
   function automatic logic [PW-1:0] build_packet(logic write, size_t size, logic [4:0] ctrl,
                                                  logic [31:0] dst, logic [31:0] data,
                                                  logic [31:0] src);
      return {src, data, dst, ctrl, size, write};
   endfunction

   function automatic int size_bytes(size_t size);
      return 1 << int'(size);
   endfunction

   // Naturally aligned lanes with the double's upper word from src
   function automatic void ref_write(size_t size, int addr, logic [31:0] data,
                                     logic [31:0] src);
      int          base;
      logic [63:0] word;
      base = addr & ~(size_bytes(size) - 1);
      word = {src, data};
      for (int i = 0; i < size_bytes(size); i++)
         ref_mem[base + i] = word[8*i +: 8];
   endfunction

   function automatic logic [PW-1:0] expected_response(size_t size, logic [4:0] ctrl, int addr,
                                                       logic [31:0] src);
      int          base;
      logic [63:0] word;
      base = addr & ~(size_bytes(size) - 1);
      word = '0;                               // Zero-extension for short reads
      for (int i = 0; i < size_bytes(size); i++)
         word[8*i +: 8] = ref_mem[base + i];
      return build_packet(1'b1, size, ctrl, src, word[31:0],
                          (size == SIZE_DOUBLE) ? word[63:32] : 32'h0);
   endfunction

   task automatic stop_with_error(string msg);
      $display("%s", msg);
      $display("SOME TESTS FAILED");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic check_equal(string name, logic [PW-1:0] actual, logic [PW-1:0] expected);
      if (actual !== expected)
         stop_with_error($sformatf("[FAIL] %s: got 0x%0h, expected 0x%0h",
                                   name, actual, expected));
   endtask

   task automatic compare_response(logic [PW-1:0] got, logic [PW-1:0] exp);
      check_equal("packet_out.data", PW'(got[`EMESH_DATA_MSB:`EMESH_DATA_LSB]),
                  PW'(exp[`EMESH_DATA_MSB:`EMESH_DATA_LSB]));
      check_equal("packet_out.srcaddr", PW'(got[`EMESH_SRC_MSB:`EMESH_SRC_LSB]),
                  PW'(exp[`EMESH_SRC_MSB:`EMESH_SRC_LSB]));
      check_equal("packet_out.dstaddr", PW'(got[`EMESH_DST_MSB:`EMESH_DST_LSB]),
                  PW'(exp[`EMESH_DST_MSB:`EMESH_DST_LSB]));
      check_equal("packet_out", got, exp);   // Ctrl, size, write bit
   endtask

   task automatic tick();
      @(posedge clk);
      #1;
   endtask

   task automatic wait_reset_release();
      int waited;
      waited = 0;
      while (nreset !== 1'b1)
      begin
         if (waited == 100)
            stop_with_error("Timeout: nreset was never released");
         waited++;
         @(posedge clk);
      end
      tick();
   endtask

   // Holds valid_in until the DUT takes the packet
   task automatic send_request(logic [PW-1:0] pkt);
      int waited;
      waited    = 0;
      valid_in  = 1'b1;
      packet_in = pkt;
      @(negedge clk);
      while (!ready_out)
      begin
         if (waited == TIMEOUT)
            stop_with_error("Timeout: ready_out did not rise for a pending request");
         waited++;
         stall_cycles++;
         @(negedge clk);
      end
      tick();                   // Accepted on this edge
      valid_in = 1'b0;
   endtask

   // Response leaves on the next edge if ready_in is high
   task automatic receive_response(output logic [PW-1:0] pkt);
      int waited;
      waited = 0;
      @(negedge clk);
      while (!valid_out)
      begin
         if (waited == TIMEOUT)
            stop_with_error("Timeout: valid_out did not rise after a read");
         waited++;
         @(negedge clk);
      end
      pkt = packet_out;
      tick();
   endtask

   task automatic do_write(size_t size, int addr, logic [31:0] data, logic [31:0] src);
      send_request(build_packet(1'b1, size, 5'(random_bits(5)), 32'(addr), data, src));
      ref_write(size, addr, data, src);
   endtask

   task automatic do_read(size_t size, int addr);
      logic [4:0]    ctrl;
      logic [31:0]   src;
      logic [PW-1:0] got;
      logic [PW-1:0] exp;
      ctrl = 5'(random_bits(5));
      src  = random_bits(32);     // Return address
      exp  = expected_response(size, ctrl, addr, src);
      send_request(build_packet(1'b0, size, ctrl, 32'(addr), random_bits(32), src));
      receive_response(got);
      compare_response(got, exp);
   endtask

   task automatic write_config(logic [8:0] value);
      cfg_write = 1'b1;
      cfg_wdata = value;
      tick();
      cfg_write = 1'b0;
   endtask

   // ####################################################################
   // Tests
   // ####################################################################

   task automatic test_reset();
      @(negedge clk);
      check_equal("valid_out", PW'(valid_out), PW'(0));
      check_equal("ready_out", PW'(ready_out), PW'(1));
      tick();
   endtask

   task automatic test_double_rw();
      for (int row = 0; row < ROWS; row++)
         do_write(SIZE_DOUBLE, row * 8, random_bits(32), random_bits(32));
      for (int row = 0; row < ROWS; row++)
         do_read(SIZE_DOUBLE, row * 8);
   endtask

   // Whole row read back after each narrow write so stray lanes show up
   task automatic test_lane_writes();
      for (int lane = 0; lane < 8; lane++)
      begin
         do_write(SIZE_BYTE, 24 + lane, random_bits(32), random_bits(32));
         do_read(SIZE_DOUBLE, 24);
      end
      for (int h = 0; h < 4; h++)
      begin
         do_write(SIZE_HALF, 32 + 2 * h, random_bits(32), random_bits(32));
         do_read(SIZE_DOUBLE, 32);
      end
      for (int w = 0; w < 2; w++)
      begin
         do_write(SIZE_WORD, 16 + 4 * w, random_bits(32), random_bits(32));
         do_read(SIZE_DOUBLE, 16);
      end
   endtask

   task automatic test_narrow_reads();
      for (int off = 0; off < 8; off++)
         do_read(SIZE_BYTE, 40 + off);
      for (int off = 0; off < 8; off += 2)
         do_read(SIZE_HALF, 40 + off);
      for (int off = 0; off < 8; off += 4)
         do_read(SIZE_WORD, 40 + off);
   endtask

   task automatic test_backpressure();
      logic [PW-1:0] exp1;
      logic [PW-1:0] exp2;
      logic [PW-1:0] got;
      int            span;
      exp1     = expected_response(SIZE_WORD, 5'h0A, 52, 32'h0000_1100);
      exp2     = expected_response(SIZE_HALF, 5'h15, 70, 32'h0000_2200);
      ready_in = 1'b0;
      send_request(build_packet(1'b0, SIZE_WORD, 5'h0A, 32'd52, 32'h0, 32'h0000_1100));
      valid_in  = 1'b1;          // Second read queued behind the first
      packet_in = build_packet(1'b0, SIZE_HALF, 5'h15, 32'd70, 32'h0, 32'h0000_2200);
      span      = 2 + int'(random_bits(4));
      for (int i = 0; i < span; i++)
      begin
         @(negedge clk);
         check_equal("valid_out", PW'(valid_out), PW'(1));
         check_equal("ready_out", PW'(ready_out), PW'(0));
         compare_response(packet_out, exp1);
         tick();
      end
      ready_in = 1'b1;           // First leaves as the second enters
      @(negedge clk);
      check_equal("ready_out", PW'(ready_out), PW'(1));
      tick();
      valid_in = 1'b0;
      receive_response(got);
      compare_response(got, exp2);
      @(negedge clk);
      check_equal("valid_out", PW'(valid_out), PW'(0));   // No duplicate
      tick();
   endtask

   task automatic test_wait_states();
      logic [1:0] code;
      int         addr;
      write_config(9'h1FF);      // Enable with mask FF
      stall_cycles = 0;
      for (int i = 0; i < 24; i++)
      begin
         code = 2'(random_bits(2));
         addr = int'(random_bits(8));
         if (random_bits(1) == 32'd1)
            do_write(size_t'(code), addr, random_bits(32), random_bits(32));
         else
            do_read(size_t'(code), addr);
      end
      if (stall_cycles == 0)
         stop_with_error("Wait enabled with mask FF but ready_out never held off a request");
      write_config(9'h000);
      tick();                    // Settings land one cycle later
      @(negedge clk);
      check_equal("ready_out", PW'(ready_out), PW'(1));
      tick();
   endtask

   // ####################################################################
   // Sequence
   // ####################################################################

   initial
   begin
      valid_in  = 1'b0;
      packet_in = '0;
      ready_in  = 1'b1;
      cfg_write = 1'b0;
      cfg_wdata = '0;
      wait_reset_release();
      test_reset();
      test_double_rw();
      test_lane_writes();
      test_narrow_reads();
      test_backpressure();
      test_wait_states();
      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

//--- vlog.f
+incdir+design
design/emesh_pkg.sv
design/emesh_unpack.sv
design/emesh_pack.sv
design/emesh_wralign.sv
design/sram_sp.sv
design/emesh_rdalign.sv
design/emesh_wait_ctrl.sv
design/emesh_memory.sv
sim/tb_clkgen.sv
sim/emesh_memory_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := emesh_memory_tb
FILELIST  := vlog.f
OBJ_DIR   := obj_dir

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard design/*.sv design/*.svh sim/*.sv)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
